// File: hw/byte_fifo.sv
// first-word-fall-through byte FIFO, circular buffer with one slot kept free
`timescale 1ns/1ps
`default_nettype none

module byte_fifo (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        push,
    input  wire uart_line_pkg::data_t  push_data,
    input  wire                        pop,
    output uart_line_pkg::data_t       pop_data,
    output logic                       empty,
    output logic                       full
);
    import uart_line_pkg::*;
    import fifo_pkg::*;

    data_t     mem [FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_ptr_t wr_next;
    logic      do_push;
    logic      do_pop;

    assign wr_next = wr_ptr + 1'b1;              // wraps at FIFO_DEPTH

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_next == rd_ptr);          // the free slot keeps full and empty apart

    assign do_push = push && !full;              // a push into a full queue is lost
    assign do_pop  = pop && !empty;

    // head is read straight from the array
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_next;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

// File: hw/fifo_pkg.sv
// byte FIFO sizing, pointer type and the host-side request/status structs
`default_nettype none

package fifo_pkg;

    localparam int FIFO_DEPTH = 16;    // one slot stays free, so 15 usable

    typedef logic [$clog2(FIFO_DEPTH)-1:0] fifo_ptr_t;

    // host write into the tx queue
    typedef struct packed {
        logic                 start;   // store data this cycle unless full
        uart_line_pkg::data_t data;
    } tx_write_t;

    // head of the rx queue as the host sees it
    typedef struct packed {
        logic                 ready;   // data below is valid
        uart_line_pkg::data_t data;
    } rx_status_t;

endpackage

`default_nettype wire

// File: hw/uart_fifo.sv
// FIFO-buffered UART top level with rx synchronizer and runtime baud divisor
`timescale 1ns/1ps
`default_nettype none

module uart_fifo (
    input  wire                           clk,
    input  wire                           rst,
    input  wire uart_line_pkg::baud_div_t baud_div,   // bit period is baud_div+1 cycles
    input  wire fifo_pkg::tx_write_t      tx_write,
    output logic                          tx_pin,
    output logic                          tx_full,
    input  wire                           rx_pin,
    input  wire                           rx_read,    // drop the head byte
    output fifo_pkg::rx_status_t          rx_status
);
    import uart_line_pkg::*;
    import fifo_pkg::*;

    logic [1:0] rx_sync;           // [1] feeds the receiver
    logic       rx_line;
    data_t      tx_head;
    logic       tx_empty;
    logic       tx_pop;
    logic       rx_done;
    data_t      rx_byte;
    data_t      rx_head;
    logic       rx_empty;

    always_ff @(posedge clk) begin
        if (rst) rx_sync <= {2{LINE_IDLE}};
        else     rx_sync <= {rx_sync[0], rx_pin};
    end
    assign rx_line = rx_sync[1];

    // transmit: host -> tx_fifo -> u_tx -> tx_pin
    byte_fifo tx_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (tx_write.start),
        .push_data (tx_write.data),
        .pop       (tx_pop),
        .pop_data  (tx_head),
        .empty     (tx_empty),
        .full      (tx_full)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst      (rst),
        .baud_div (baud_div),
        .pop_data (tx_head),
        .empty    (tx_empty),
        .pop      (tx_pop),
        .tx_pin   (tx_pin)
    );

    // receive: rx_line -> u_rx -> rx_fifo -> host, overflow bytes are dropped
    uart_rx u_rx (
        .clk      (clk),
        .rst      (rst),
        .baud_div (baud_div),
        .rx_line  (rx_line),
        .done     (rx_done),
        .data     (rx_byte)
    );

    byte_fifo rx_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (rx_done),
        .push_data (rx_byte),
        .pop       (rx_read),
        .pop_data  (rx_head),
        .empty     (rx_empty),
        .full      ()
    );

    assign rx_status.ready = !rx_empty;
    assign rx_status.data  = rx_head;

endmodule

`default_nettype wire

// File: hw/uart_line_pkg.sv
// uart line format: character and divisor types, frame levels and engine states
`default_nettype none

package uart_line_pkg;

    localparam int DATA_BITS = 8;      // 8N1 frame

    // one character as it travels on the line
    typedef logic [DATA_BITS-1:0] data_t;

    // bit period minus one, in clock cycles
    typedef logic [15:0] baud_div_t;

    // which data bit is on the line right now
    typedef logic [$clog2(DATA_BITS)-1:0] bit_index_t;

    localparam logic LINE_IDLE   = 1'b1;  // idle line and stop bit
    localparam logic START_LEVEL = 1'b0;

    // shared by the transmitter and the receiver
    typedef enum logic [1:0] {
        IDLE,
        START_BIT,
        DATA_BIT,
        STOP_BIT
    } line_state_t;

endpackage

`default_nettype wire

// File: hw/uart_rx.sv
// 8N1 receiver, samples the synchronized line at bit centres and strobes each byte
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire                           clk,
    input  wire                           rst,
    input  wire uart_line_pkg::baud_div_t baud_div,
    input  wire                           rx_line,   // already synchronized
    output logic                          done,      // one cycle, data is valid
    output uart_line_pkg::data_t          data
);
    import uart_line_pkg::*;

    line_state_t state;
    baud_div_t   timer;
    bit_index_t  bit_idx;
    logic        timer_zero;
    logic        last_bit;

    assign timer_zero = (timer == '0);
    assign last_bit   = (bit_idx == bit_index_t'(DATA_BITS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            timer   <= '0;
            bit_idx <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (rx_line == START_LEVEL) begin
                        state <= START_BIT;
                        timer <= baud_div >> 1;      // go to the middle of the start bit
                    end
                end

                START_BIT: begin
                    if (timer_zero) begin
                        // still low at mid-bit, otherwise it was a glitch
                        if (rx_line == START_LEVEL) begin
                            state   <= DATA_BIT;
                            timer   <= baud_div;
                            bit_idx <= '0;
                        end else begin
                            state <= IDLE;
                        end
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end

                DATA_BIT: begin
                    if (timer_zero) begin
                        timer <= baud_div;
                        if (last_bit) state <= STOP_BIT;
                        else          bit_idx <= bit_idx + 1'b1;
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end

                STOP_BIT: begin
                    // stop level is not checked
                    if (timer_zero) begin
                        done  <= 1'b1;
                        state <= IDLE;
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == DATA_BIT && timer_zero) begin
            data <= {rx_line, data[DATA_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

// File: hw/uart_tx.sv
// 8N1 transmitter, pops the tx FIFO when idle and serializes the byte onto tx_pin
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire                           clk,
    input  wire                           rst,
    input  wire uart_line_pkg::baud_div_t baud_div,
    input  wire uart_line_pkg::data_t     pop_data,
    input  wire                           empty,
    output logic                          pop,
    output logic                          tx_pin
);
    import uart_line_pkg::*;

    line_state_t state;
    baud_div_t   timer;
    bit_index_t  bit_idx;
    data_t       tx_shift;         // bit 0 is the next data bit
    logic        timer_zero;
    logic        last_bit;
    logic        shift_out;

    assign timer_zero = (timer == '0);
    assign last_bit   = (bit_idx == bit_index_t'(DATA_BITS - 1));

    assign pop = (state == IDLE) && !empty;     // one cycle, state leaves IDLE on the same edge

    // a new data bit goes out at the end of the start bit and of every data bit but the last
    assign shift_out = timer_zero &&
                       ((state == START_BIT) || (state == DATA_BIT && !last_bit));

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            timer   <= '0;
            bit_idx <= '0;
            tx_pin  <= LINE_IDLE;
        end else begin
            case (state)
                IDLE: begin
                    tx_pin <= LINE_IDLE;
                    if (pop) begin
                        tx_pin <= START_LEVEL;
                        timer  <= baud_div;
                        state  <= START_BIT;
                    end
                end

                START_BIT: begin
                    if (timer_zero) begin
                        tx_pin  <= tx_shift[0];
                        timer   <= baud_div;
                        bit_idx <= '0;
                        state   <= DATA_BIT;
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end

                DATA_BIT: begin
                    if (timer_zero) begin
                        timer <= baud_div;
                        if (last_bit) begin
                            tx_pin <= LINE_IDLE;   // stop bit
                            state  <= STOP_BIT;
                        end else begin
                            tx_pin  <= tx_shift[0];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end

                STOP_BIT: begin
                    if (timer_zero) state <= IDLE;
                    else            timer <= timer - 1'b1;
                end

                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop)            tx_shift <= pop_data;
        else if (shift_out) tx_shift <= tx_shift >> 1;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build the uart_fifo testbench with Verilator, run it and judge the log

set -u

cd "$(dirname "$0")" || exit 1

TOP=uart_fifo_tb
OBJ_DIR=obj_dir
LOG=sim.log
PASS_TEXT='*** TEST PASSED ***'

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

if ! verilator --binary --timing --assert \
        --timescale 1ns/1ps \
        --top-module "$TOP" \
        -Mdir "$OBJ_DIR" \
        -f uart_fifo.f; then
    echo "build failed"
    exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
fi

if grep -qF "$PASS_TEXT" "$LOG"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1

// File: testbench/uart_fifo_assertions.sv
// bound checks on the uart_fifo ports: reset levels and stability of the rx head byte
`timescale 1ns/1ps
`default_nettype none

module uart_fifo_assertions (
    input wire                       clk,
    input wire                       rst,
    input wire                       tx_pin,
    input wire                       tx_full,
    input wire                       rx_read,
    input wire fifo_pkg::rx_status_t rx_status
);
    import fifo_pkg::*;

    // tx_pin is registered, it shows the idle level one edge after rst is seen
    tx_idle_in_reset: assert property (@(posedge clk) rst |=> tx_pin == 1'b1)
        else $error("tx_pin is not high during reset");

    flags_clear_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !rx_status.ready && !tx_full)
        else $error("ready or tx_full set in the first cycle after reset");

    // a push never lands in the head slot, only a read may change it
    head_stable: assert property (@(posedge clk) disable iff (rst)
        rx_status.ready && !rx_read |=> $stable(rx_status.data))
        else $error("rx head byte changed without a read");

endmodule

bind uart_fifo uart_fifo_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .tx_pin    (tx_pin),
    .tx_full   (tx_full),
    .rx_read   (rx_read),
    .rx_status (rx_status)
);

`default_nettype wire

// File: testbench/uart_fifo_tb.sv
// testbench for the FIFO-buffered UART: tx burst, rx frames, rx overflow and glitch rejection
`timescale 1ns/1ps
`default_nettype none

module uart_fifo_tb;
    import uart_line_pkg::*;
    import fifo_pkg::*;

    typedef enum int {TX_BURST, RX_FRAMES, RX_OVERFLOW, RX_GLITCH} test_kind_t;

    localparam int        NUM_TESTS     = 4;
    localparam int        CLK_HALF      = 4;       // 8 ns period
    localparam int        RESET_CYCLES  = 16;
    localparam int        MARGIN_CYCLES = 1000;
    localparam int        FRAME_BITS    = 10;      // start, 8 data, stop
    localparam baud_div_t DIV           = 16'd7;
    localparam int        BIT_CYCLES    = int'(DIV) + 1;
    localparam int        RX_CAPACITY   = FIFO_DEPTH - 1;

    // stimulus table, one row per test
    string      test_name [NUM_TESTS] = '{"tx_burst", "rx_frames", "rx_overflow", "rx_glitch"};
    test_kind_t test_kind [NUM_TESTS] = '{TX_BURST, RX_FRAMES, RX_OVERFLOW, RX_GLITCH};
    int         test_count[NUM_TESTS] = '{20, 5, 17, 1};

    logic       clk;
    logic       rst;
    baud_div_t  baud_div;
    tx_write_t  tx_write;
    logic       tx_pin;
    logic       tx_full;
    logic       rx_pin;
    logic       rx_read;
    rx_status_t rx_status;

    logic [31:0] lfsr_state = 32'hafbdb6e7;
    string       cur_test   = "reset";
    bit          fail_shown;
    bit          run_ok;
    data_t       tx_seen[$];               // bytes decoded from tx_pin

    uart_fifo uart_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .baud_div  (baud_div),
        .tx_write  (tx_write),
        .tx_pin    (tx_pin),
        .tx_full   (tx_full),
        .rx_pin    (rx_pin),
        .rx_read   (rx_read),
        .rx_status (rx_status)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_byte(output data_t b);
        for (int i = 0; i < DATA_BITS; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b[i] = lfsr_state[0];      // one step per bit
        end
    endtask

    task automatic abort_run();
        fail_shown = 1'b1;
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
            abort_run();
        end
    endtask

    // one line level for a full bit time, entered and left 1 ns after an edge
    task automatic drive_bit(input logic level);
        rx_pin = level;
        repeat (BIT_CYCLES) @(posedge clk);
        #1;
    endtask

    task automatic send_frame(input data_t b);
        drive_bit(START_LEVEL);
        for (int i = 0; i < DATA_BITS; i++) drive_bit(b[i]);   // LSB first
        drive_bit(LINE_IDLE);
    endtask

    task automatic run_tx_burst(input int count);
        data_t expected_q[$];
        data_t b;
        bit    saw_full;
        saw_full = 1'b0;
        tx_seen.delete();
        for (int i = 0; i < count; i++) begin
            random_byte(b);
            tx_write.start = 1'b1;
            tx_write.data  = b;
            if (!tx_full) expected_q.push_back(b);     // stored at the coming edge
            else          saw_full = 1'b1;
            @(posedge clk);
            #1;
        end
        tx_write = '0;
        while (tx_seen.size() < expected_q.size()) @(posedge clk);
        repeat ((FRAME_BITS + 1) * BIT_CYCLES) @(posedge clk);   // room for a stray extra frame
        #1;
        check("tx_full seen", 1, 32'(saw_full));
        check("tx_full cleared", 0, 32'(tx_full));
        check("frame count", expected_q.size(), tx_seen.size());
        foreach (expected_q[i]) check("tx byte", 32'(expected_q[i]), 32'(tx_seen[i]));
    endtask

    task automatic run_rx_frames(input int count);
        data_t sent_q[$];
        data_t b;
        for (int i = 0; i < count; i++) begin
            random_byte(b);
            send_frame(b);
            if (i < RX_CAPACITY) sent_q.push_back(b);  // later ones find the FIFO full
        end
        repeat (BIT_CYCLES) @(posedge clk);            // last byte settles into the FIFO
        #1;
        foreach (sent_q[i]) begin
            check("ready", 1, 32'(rx_status.ready));
            check("rx byte", 32'(sent_q[i]), 32'(rx_status.data));
            rx_read = 1'b1;
            @(posedge clk);
            #1;
            rx_read = 1'b0;
        end
        check("ready after reads", 0, 32'(rx_status.ready));
    endtask

    task automatic run_rx_glitch(input int count);
        for (int g = 0; g < count; g++) begin
            rx_pin = START_LEVEL;                      // shorter than half a bit
            repeat (2) @(posedge clk);
            #1;
            rx_pin = LINE_IDLE;
            for (int c = 0; c < 2 * FRAME_BITS * BIT_CYCLES; c++) begin
                @(posedge clk);
                #1;
                check("ready after glitch", 0, 32'(rx_status.ready));
            end
        end
    endtask

    // tx line decoder, samples on the falling clock edge
    initial begin : tx_monitor
        data_t b;
        forever begin
            @(negedge clk);
            if (tx_pin === START_LEVEL && rst === 1'b0) begin
                repeat (BIT_CYCLES / 2) @(negedge clk);    // middle of the start bit
                check("start bit", 32'(START_LEVEL), 32'(tx_pin));
                for (int i = 0; i < DATA_BITS; i++) begin
                    repeat (BIT_CYCLES) @(negedge clk);
                    b[i] = tx_pin;
                end
                repeat (BIT_CYCLES) @(negedge clk);
                check("stop bit", 32'(LINE_IDLE), 32'(tx_pin));
                tx_seen.push_back(b);
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = RESET_CYCLES + MARGIN_CYCLES;
        for (int i = 0; i < NUM_TESTS; i++) limit += test_count[i] * 12 * BIT_CYCLES;
        repeat (limit) @(posedge clk);
        $display("ERROR: run timed out after %0d clock cycles in test %s", limit, cur_test);
        abort_run();
    end

    initial begin : stimulus
        rst      = 1'b1;
        baud_div = DIV;
        tx_write = '0;
        rx_pin   = LINE_IDLE;
        rx_read  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        @(posedge clk);
        #1;
        check("tx_pin idle", 1, 32'(tx_pin));
        check("tx_full", 0, 32'(tx_full));
        check("ready", 0, 32'(rx_status.ready));
        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_test = test_name[t];
            case (test_kind[t])
                TX_BURST:    run_tx_burst(test_count[t]);
                RX_FRAMES,
                RX_OVERFLOW: run_rx_frames(test_count[t]);
                RX_GLITCH:   run_rx_glitch(test_count[t]);
            endcase
        end
        run_ok = 1'b1;
        $display("*** TEST PASSED ***");
        $finish;
    end

    final begin
        if (!run_ok && !fail_shown) $display("*** TEST FAILED ***");
    end

endmodule

`default_nettype wire

// File: uart_fifo.f
hw/uart_line_pkg.sv
hw/fifo_pkg.sv
hw/byte_fifo.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/uart_fifo.sv
testbench/uart_fifo_assertions.sv
testbench/uart_fifo_tb.sv
